/* sim/cpuGolden.txt */
# I word: next program word | M addr value: initial data word | S addr value: expected store
# E flag: expected err at halt, ends a section; all values hex
I C1F3  # lbi r1, -13
I C225  # lbi r2, 0x25
I C740  # lbi r7, 0x40
I 417C  # addi r3, r1, -4
I 8760  # st r3, [r7+0]
I 4A9C  # subi r4, r2, -4
I 8782  # st r4, [r7+2]
I 52BC  # xori r5, r2, 0x1c
I 87A4  # st r5, [r7+4]
I 59D3  # andni r6, r1, 0x13
I 87C6  # st r6, [r7+6]
I D94C  # add r3, r1, r2
I 8768  # st r3, [r7+8]
I D951  # sub r4, r1, r2
I 878A  # st r4, [r7+10]
I D956  # xor r5, r1, r2
I 87AC  # st r5, [r7+12]
I D95B  # andn r6, r1, r2
I 87CE  # st r6, [r7+14]
I C020  # lbi r0, 0x20
I 8820  # ld r1, [r0+0]
I 8024  # st r1, [r0+4]
I 413F  # addi r1, r1, -1
I 803E  # st r1, [r0-2]
I 0000  # halt
I 8760  # never executes
M 0020 BEEF
S 0040 FFEF
S 0042 FFD7
S 0044 0039
S 0046 FFE0
S 0048 0018
S 004A 0032
S 004C FFD6
S 004E FFD2
S 0024 BEEF
S 001E BEEE
E 0
# second section, one undefined opcode between legal stores
I C112  # lbi r1, 0x12
I 8120  # st r1, [r1+0]
I 0800  # nop
I F800  # undefined opcode
I 4142  # addi r2, r1, 2
I 8142  # st r2, [r1+2]
I 0000  # halt
S 0012 0012
S 0014 0014
E 1

/* flist.f */
design/cpuPkg.sv
design/pipeReg.sv
design/fetchUnit.sv
design/instrDecoder.sv
design/hazardDetector.sv
design/regFile.sv
design/aluUnit.sv
design/memAccess.sv
design/cpuCore.sv
sim/tbCpuCore.sv

/* Makefile */
BUILD := obj_dir
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module tbCpuCore

sim:
	verilator --binary --timing --assert -f flist.f --top-module tbCpuCore \
		--Mdir $(BUILD) -o simv
	./$(BUILD)/simv > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/tbCpuCore.sv */
`timescale 1ns/1ps

module tbCpuCore import cpuPkg::*; ();

    localparam int memWords    = 256;
    localparam int haltTimeout = 2000;
    localparam int drainCycles = 8;

    // golden file characters
    localparam int charTab   = 9;
    localparam int charLf    = 10;
    localparam int charCr    = 13;
    localparam int charSpace = 32;
    localparam int charHash  = 35;
    localparam int tagErr    = 69;
    localparam int tagInstr  = 73;
    localparam int tagMem    = 77;
    localparam int tagStore  = 83;

    logic                 clk;
    logic                 rstN;
    logic [dataWidth-1:0] imemAddr;
    logic [dataWidth-1:0] imemData;
    dmemReqT              dmemReq;
    logic [dataWidth-1:0] dmemRdata;
    logic                 halted;
    logic                 err;

    logic [dataWidth-1:0] imem [memWords];
    logic [dataWidth-1:0] dmem [memWords];
    // {addr, data} in program order
    logic [31:0]          expStores [$];
    int                   goldenFd;

    cpuCore #(.resetPc(16'h0000)) DUT (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .dmemReq  (dmemReq),
        .dmemRdata(dmemRdata),
        .halted   (halted),
        .err      (err)
    );

    // both memories read combinationally, word index is addr / 2
    assign imemData  = imem[imemAddr[8:1]];
    // data only shows up while the read strobe is set
    assign dmemRdata = dmemReq.read ? dmem[dmemReq.addr[8:1]] : 'x;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abortRun();
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    task automatic compareValue(input string name, input logic [dataWidth-1:0] got,
                                input logic [dataWidth-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic clearMemories();
        for (int i = 0; i < memWords; i++) begin
            // unprogrammed words decode as HALT
            imem[i[7:0]] = '0;
            dmem[i[7:0]] = 16'(i * 40503) ^ 16'h3c5a;
        end
    endtask

    // next tag character, skipping blanks and # comments
    task automatic nextTag(output int tag);
        int c;
        c = $fgetc(goldenFd);
        while (c == charSpace || c == charLf || c == charCr || c == charTab || c == charHash) begin
            if (c == charHash) begin
                while (c != charLf && c != -1) begin
                    c = $fgetc(goldenFd);
                end
            end
            c = $fgetc(goldenFd);
        end
        tag = c;
    endtask

    // loads memories and expected stores up to the next E line
    task automatic readSection(output bit found, output logic expErr);
        int                   tag;
        int                   n;
        int                   want;
        logic [7:0]           pc;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] d;
        found  = 1'b0;
        expErr = 1'b0;
        pc     = '0;
        clearMemories();
        expStores.delete();
        nextTag(tag);
        while (tag != -1 && !found) begin
            if (tag == tagInstr) begin
                want = 1;
                n = $fscanf(goldenFd, "%h", d);
                imem[pc] = d;
                pc++;
            end else if (tag == tagMem) begin
                want = 2;
                n = $fscanf(goldenFd, "%h %h", a, d);
                dmem[a[8:1]] = d;
            end else if (tag == tagStore) begin
                want = 2;
                n = $fscanf(goldenFd, "%h %h", a, d);
                expStores.push_back({a, d});
            end else if (tag == tagErr) begin
                want = 1;
                n = $fscanf(goldenFd, "%h", d);
                expErr = d[0];
                found = 1'b1;
            end else begin
                $display("golden file holds an unknown tag character %0d", tag);
                abortRun();
            end
            if (n != want) begin
                $display("golden file line with tag %0d is malformed", tag);
                abortRun();
            end
            if (!found) begin
                nextTag(tag);
            end
        end
        if (!found && pc != 0) begin
            $display("golden file ends inside a section with no E line");
            abortRun();
        end
    endtask

    task automatic runSection(input logic expErr);
        int cycles;
        rstN = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        compareValue("halted", {{(dataWidth-1){1'b0}}, halted}, '0);
        compareValue("err", {{(dataWidth-1){1'b0}}, err}, '0);
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (cycles > haltTimeout) begin
                $display("processor never halted within %0d cycles", haltTimeout);
                abortRun();
            end
        end
        // anything behind HALT would show up here
        repeat (drainCycles) @(negedge clk);
        if (expStores.size() != 0) begin
            $display("processor halted with %0d expected stores never seen", expStores.size());
            abortRun();
        end
        compareValue("err", {{(dataWidth-1){1'b0}}, err}, {{(dataWidth-1){1'b0}}, expErr});
    endtask

    task automatic checkStore();
        logic [31:0] exp;
        if (expStores.size() == 0) begin
            $display("unexpected store of %h to %h", dmemReq.wdata, dmemReq.addr);
            abortRun();
        end else if (dmemReq.addr[15:9] != '0) begin
            $display("store to %h lies outside the modeled data memory", dmemReq.addr);
            abortRun();
        end else begin
            exp = expStores.pop_front();
            compareValue("dmemReq.addr", dmemReq.addr, exp[31:16]);
            compareValue("dmemReq.wdata", dmemReq.wdata, exp[15:0]);
            dmem[dmemReq.addr[8:1]] = dmemReq.wdata;
        end
    endtask

    // mid-cycle, the request is stable
    always @(negedge clk) begin
        if (rstN && dmemReq.write) begin
            checkStore();
        end
    end

    initial begin
        bit   found;
        logic expErr;
        int   sections;
        rstN = 1'b0;
        clearMemories();
        sections = 0;
        goldenFd = $fopen("sim/cpuGolden.txt", "r");
        if (goldenFd == 0) begin
            $display("cannot open sim/cpuGolden.txt");
            abortRun();
        end
        readSection(found, expErr);
        while (found) begin
            runSection(expErr);
            sections++;
            readSection(found, expErr);
        end
        $fclose(goldenFd);
        if (sections == 0) begin
            $display("golden file holds no complete section");
            abortRun();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* design/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; #(
    parameter logic [dataWidth-1:0] resetPc = '0
) (
    input  logic                 clk,
    input  logic                 rstN,
    output logic [dataWidth-1:0] imemAddr,
    input  logic [dataWidth-1:0] imemData,
    output dmemReqT              dmemReq,
    input  logic [dataWidth-1:0] dmemRdata,
    output logic                 halted,
    output logic                 err
);

    // stage payloads, D side and Q side of each pipeline register
    ifIdT  ifIdQ;
    idExT  idExD;
    idExT  idExQ;
    exMemT exMemD;
    exMemT exMemQ;
    memWbT memWbD;
    memWbT memWbQ;

    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [dataWidth-1:0]    rsData;
    logic [dataWidth-1:0]    rtData;
    logic                    rsUsed;
    logic                    rtUsed;
    logic                    idHalt;
    logic                    stall;
    logic                    hold;

    fetchUnit #(.resetPc(resetPc)) fetch (
        .clk (clk),
        .rstN(rstN),
        .hold(hold),
        .pc  (imemAddr)
    );

    // only IF/ID ever freezes
    pipeReg #(.payloadT(ifIdT)) ifIdReg (
        .clk (clk),
        .rstN(rstN),
        .en  (!hold),
        .d   (imemData),
        .q   (ifIdQ)
    );

    instrDecoder decoder (
        .clk   (clk),
        .rstN  (rstN),
        .instr (ifIdQ),
        .stall (stall),
        .rsData(rsData),
        .rtData(rtData),
        .rsAddr(rsAddr),
        .rtAddr(rtAddr),
        .rsUsed(rsUsed),
        .rtUsed(rtUsed),
        .idHalt(idHalt),
        .idOut (idExD),
        .err   (err)
    );

    hazardDetector hazard (
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsUsed (rsUsed),
        .rtUsed (rtUsed),
        .idHalt (idHalt),
        .exCtrl (idExQ.ctrl),
        .memCtrl(exMemQ.ctrl),
        .stall  (stall),
        .hold   (hold)
    );

    regFile regs (
        .clk   (clk),
        .rstN  (rstN),
        .rsAddr(rsAddr),
        .rtAddr(rtAddr),
        .rsData(rsData),
        .rtData(rtData),
        .wrEn  (memWbQ.ctrl.regWrite),
        .wrAddr(memWbQ.ctrl.destReg),
        .wrData(memWbQ.result)
    );

    pipeReg #(.payloadT(idExT)) idExReg (
        .clk (clk),
        .rstN(rstN),
        .en  (1'b1),
        .d   (idExD),
        .q   (idExQ)
    );

    aluUnit alu (
        .exIn (idExQ),
        .exOut(exMemD)
    );

    pipeReg #(.payloadT(exMemT)) exMemReg (
        .clk (clk),
        .rstN(rstN),
        .en  (1'b1),
        .d   (exMemD),
        .q   (exMemQ)
    );

    memAccess mem (
        .clk      (clk),
        .rstN     (rstN),
        .memIn    (exMemQ),
        .dmemReq  (dmemReq),
        .dmemRdata(dmemRdata),
        .wbOut    (memWbD),
        .halted   (halted)
    );

    pipeReg #(.payloadT(memWbT)) memWbReg (
        .clk (clk),
        .rstN(rstN),
        .en  (1'b1),
        .d   (memWbD),
        .q   (memWbQ)
    );

endmodule

/* design/memAccess.sv */
`timescale 1ns/1ps

module memAccess import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  exMemT                memIn,
    output dmemReqT              dmemReq,
    input  logic [dataWidth-1:0] dmemRdata,
    output memWbT                wbOut,
    output logic                 halted
);

    assign dmemReq = '{
        read:  memIn.ctrl.memRead,
        write: memIn.ctrl.memWrite,
        addr:  memIn.aluResult,
        wdata: memIn.storeData
    };

    assign wbOut = '{
        ctrl:   memIn.ctrl,
        result: memIn.ctrl.memRead ? dmemRdata : memIn.aluResult
    };

    // sticky once HALT clears MEM
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (memIn.ctrl.halt) begin
            halted <= 1'b1;
        end
    end

    reqExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(dmemReq.read && dmemReq.write)
    ) else $error("data memory read and write in the same cycle");

    reqAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        (dmemReq.read || dmemReq.write) |-> !dmemReq.addr[0]
    ) else $error("unaligned data access at %h", dmemReq.addr);

    // nothing behind HALT may reach memory
    noStoreAfterHalt: assert property (
        @(posedge clk) disable iff (!rstN)
        halted |-> !dmemReq.write
    ) else $error("store issued after halt");

endmodule

/* design/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import cpuPkg::*; (
    input  idExT  exIn,
    output exMemT exOut
);

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] result;

    assign opA = exIn.rsData;
    assign opB = exIn.ctrl.useImm ? exIn.imm : exIn.rtData;

    always_comb begin
        case (exIn.ctrl.aluOp)
            aluAdd:   result = opA + opB;
            // reversed subtract, rt minus rs or imm minus rs
            aluSub:   result = opB - opA;
            aluXor:   result = opA ^ opB;
            aluAndn:  result = opA & ~opB;
            aluPassB: result = opB;
            default:  result = '0;
        endcase
    end

    // rt always rides along as store data
    assign exOut = '{ctrl: exIn.ctrl, aluResult: result, storeData: exIn.rtData};

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [regAddrWidth-1:0] rsAddr,
    input  logic [regAddrWidth-1:0] rtAddr,
    output logic [dataWidth-1:0]    rsData,
    output logic [dataWidth-1:0]    rtData,
    input  logic                    wrEn,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0]    wrData
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-through so ID sees what WB writes this cycle
    assign rsData = (wrEn && wrAddr == rsAddr) ? wrData : regs[rsAddr];
    assign rtData = (wrEn && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

/* design/hazardDetector.sv */
`timescale 1ns/1ps

module hazardDetector import cpuPkg::*; (
    input  logic [regAddrWidth-1:0] rsAddr,
    input  logic [regAddrWidth-1:0] rtAddr,
    input  logic                    rsUsed,
    input  logic                    rtUsed,
    input  logic                    idHalt,
    input  ctrlT                    exCtrl,
    input  ctrlT                    memCtrl,
    output logic                    stall,
    output logic                    hold
);

    logic rsHit;
    logic rtHit;

    // WB needs no check, the register file bypasses its write
    assign rsHit = rsUsed && ((exCtrl.regWrite && exCtrl.destReg == rsAddr) ||
                              (memCtrl.regWrite && memCtrl.destReg == rsAddr));
    assign rtHit = rtUsed && ((exCtrl.regWrite && exCtrl.destReg == rtAddr) ||
                              (memCtrl.regWrite && memCtrl.destReg == rtAddr));

    assign stall = rsHit || rtHit;
    assign hold  = stall || idHalt;

endmodule

/* design/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  ifIdT                    instr,
    input  logic                    stall,
    input  logic [dataWidth-1:0]    rsData,
    input  logic [dataWidth-1:0]    rtData,
    output logic [regAddrWidth-1:0] rsAddr,
    output logic [regAddrWidth-1:0] rtAddr,
    output logic                    rsUsed,
    output logic                    rtUsed,
    output logic                    idHalt,
    output idExT                    idOut,
    output logic                    err
);

    opcodeT               opcode;
    ctrlT                 ctrl;
    logic                 legal;
    logic                 fetchLive;
    logic [dataWidth-1:0] imm5Sext;
    logic [dataWidth-1:0] imm5Zext;
    logic [dataWidth-1:0] imm8Sext;
    logic [dataWidth-1:0] imm;

    // low two bits pick add/sub/xor/andn, both for the func field and the imm opcodes
    function automatic aluOpT aluFromSel(input logic [1:0] sel);
        aluOpT op;
        case (sel)
            2'b00:   op = aluAdd;
            2'b01:   op = aluSub;
            2'b10:   op = aluXor;
            default: op = aluAndn;
        endcase
        return op;
    endfunction

    assign opcode   = opcodeT'(instr[15:11]);
    assign rsAddr   = instr[10:8];
    assign rtAddr   = instr[7:5];
    assign imm5Sext = {{(dataWidth-5){instr[4]}}, instr[4:0]};
    assign imm5Zext = {{(dataWidth-5){1'b0}}, instr[4:0]};
    assign imm8Sext = {{(dataWidth-8){instr[7]}}, instr[7:0]};

    always_comb begin
        ctrl   = '0;
        imm    = '0;
        legal  = 1'b1;
        rsUsed = 1'b0;
        rtUsed = 1'b0;
        case (opcode)
            opHalt: ctrl.halt = 1'b1;
            opNop: ;
            opAddi, opSubi, opXori, opAndni: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = aluFromSel(instr[12:11]);
                ctrl.destReg  = rtAddr;
                rsUsed        = 1'b1;
                // logical immediates are zero-extended
                imm = instr[12] ? imm5Zext : imm5Sext;
            end
            opSt: begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = aluAdd;
                imm           = imm5Sext;
                rsUsed        = 1'b1;
                rtUsed        = 1'b1;
            end
            opLd: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = aluAdd;
                ctrl.destReg  = rtAddr;
                imm           = imm5Sext;
                rsUsed        = 1'b1;
            end
            opLbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = aluPassB;
                ctrl.destReg  = rsAddr;
                imm           = imm8Sext;
            end
            opRform: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFromSel(instr[1:0]);
                ctrl.destReg  = instr[4:2];
                rsUsed        = 1'b1;
                rtUsed        = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // IF/ID comes out of reset as all zeros, which encodes HALT
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchLive <= 1'b0;
            err       <= 1'b0;
        end else begin
            fetchLive <= 1'b1;
            if (fetchLive && !legal) begin
                err <= 1'b1;
            end
        end
    end

    assign idHalt = fetchLive && (opcode == opHalt);

    always_comb begin
        if (stall || !legal || !fetchLive) begin
            idOut = '0;
        end else begin
            idOut = '{ctrl: ctrl, rsData: rsData, rtData: rtData, imm: imm};
        end
    end

endmodule

/* design/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; #(
    parameter logic [dataWidth-1:0] resetPc = '0
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 hold,
    output logic [dataWidth-1:0] pc
);

    // word-aligned byte addresses, so step by two
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (!hold) begin
            pc <= pc + dataWidth'(2);
        end
    end

    // odd fetch address would mean a bad resetPc or a broken increment
    pcEven: assert property (
        @(posedge clk) disable iff (!rstN)
        !pc[0]
    ) else $error("fetch PC is odd: %h", pc);

endmodule

/* design/pipeReg.sv */
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    en,
    input  payloadT d,
    output payloadT q
);

    // zero payload is a bubble in every stage
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

/* design/cpuPkg.sv */
package cpuPkg;

    // machine word and register index widths
    parameter int dataWidth    = 16;
    parameter int regAddrWidth = 3;

    // 5-bit major opcodes, instr[15:11]
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opLbi   = 5'b11000,
        opRform = 5'b11011
    } opcodeT;

    // aluSub is B minus A, aluAndn is A and not B
    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluXor   = 3'd2,
        aluAndn  = 3'd3,
        aluPassB = 3'd4
    } aluOpT;

    // all zero means a bubble
    typedef struct packed {
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        logic                    halt;
        logic                    useImm;
        aluOpT                   aluOp;
        logic [regAddrWidth-1:0] destReg;
    } ctrlT;

    // IF/ID carries the raw instruction word
    typedef logic [dataWidth-1:0] ifIdT;

    typedef struct packed {
        ctrlT                 ctrl;
        logic [dataWidth-1:0] rsData;
        logic [dataWidth-1:0] rtData;
        logic [dataWidth-1:0] imm;
    } idExT;

    typedef struct packed {
        ctrlT                 ctrl;
        logic [dataWidth-1:0] aluResult;
        logic [dataWidth-1:0] storeData;
    } exMemT;

    typedef struct packed {
        ctrlT                 ctrl;
        logic [dataWidth-1:0] result;
    } memWbT;

    // data memory request, byte address
    typedef struct packed {
        logic                 read;
        logic                 write;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } dmemReqT;

endpackage
